//--- hw/sm_alu_macros.svh
`ifndef SM_ALU_MACROS_SVH
`define SM_ALU_MACROS_SVH

////////////////////
// datapath sizing.
////////////////////

// width of one operand magnitude, sign bits travel separately.
`define SM_WIDTH 32

// number of registered stages between in and out.
// resolve, subtract and fix-up each hold one entry.
`define SM_STAGES 3

// an item accepted on one edge leaves the last register
// SM_STAGES edges later when nothing stalls.

`endif

//--- hw/sm_alu_pkg.sv
`include "sm_alu_macros.svh"

package sm_alu_pkg;

    ////////////////////
    // operand and opcode types.
    ////////////////////

    // one unsigned magnitude.
    typedef logic [`SM_WIDTH-1:0] sm_mag_t;

    // requested operation, before the signs are looked at.
    typedef enum logic {
        SM_ADD = 1'b0, // a plus b.
        SM_SUB = 1'b1  // a minus b.
    } sm_op_e;

    ////////////////////
    // stage payloads.
    ////////////////////

    // after operation resolve.
    // the opcode and both signs are folded into two flags here.
    typedef struct packed {
        sm_mag_t a;       // magnitude of a.
        sm_mag_t b;       // magnitude of b.
        logic    eff_sub; // magnitudes are subtracted, not added.
        logic    neg;     // provisional sign, taken from a alone.
    } sm_resolve_t;

    // after the magnitude add or subtract.
    typedef struct packed {
        sm_mag_t diff;    // raw sum or a minus b, wrapped.
        logic    borrow;  // set when a < b on a subtract.
        logic    eff_sub; // carried along from stage one.
        logic    neg;     // still the provisional sign.
    } sm_diff_t;

    // final result as seen on the output stream.
    // a negative zero can show up here when a equals b and a is negative.
    typedef struct packed {
        sm_mag_t mag; // result magnitude.
        logic    neg; // 1 means the result is negative.
    } sm_result_t;

endpackage

//--- hw/sm_pipe_reg.sv
`timescale 1ns/1ns

// one-entry register slice on a valid/ready stream.
// a full slice that is drained and refilled on the same edge
// keeps the stream moving at one item per cycle.
module sm_pipe_reg #(
    parameter type T = logic // payload carried by this slice.
) (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,  // upstream offers an item.
    input  T     in_data,
    output logic in_ready,  // this slice can take an item this cycle.
    output logic out_valid, // this slice holds an item.
    output T     out_data,
    input  logic out_ready  // downstream takes the held item.
);

    logic full; // slice holds a valid entry.
    T     data_q; // the held payload.

    // room when empty, or when the entry leaves on this edge.
    assign in_ready = ~full | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid; // refill, or go empty when nothing arrives.
        end
    end

    // payload follows the load condition of the flag.
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q; // held stable while out_ready is low.

endmodule

//--- hw/sm_op_resolve.sv
`timescale 1ns/1ns

// stage one of the sign-magnitude adder.
// turns the requested operation and the two signs into the operation that
// the magnitudes really see, and registers the result.
module sm_op_resolve (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  sm_alu_pkg::sm_op_e       in_op,    // requested add or subtract.
    input  sm_alu_pkg::sm_mag_t      in_a,
    input  logic                     in_a_pos, // 1 means a is positive or zero.
    input  sm_alu_pkg::sm_mag_t      in_b,
    input  logic                     in_b_pos, // 1 means b is positive or zero.
    output logic                     in_ready,
    output logic                     out_valid,
    output sm_alu_pkg::sm_resolve_t  out_data,
    input  logic                     out_ready
);

    import sm_alu_pkg::*;

    logic        signs_agree; // a and b carry the same sign.
    logic        eff_add;     // magnitudes get added.
    sm_resolve_t stage_d;     // payload into the register.

    ////////////////////
    // operation resolve.
    ////////////////////

    assign signs_agree = ~(in_a_pos ^ in_b_pos);

    // an add of unlike signs is really a subtract.
    // a subtract of unlike signs is really an add.
    always_comb begin
        if (in_op == SM_ADD) begin
            eff_add = signs_agree;
        end else begin
            eff_add = ~signs_agree;
        end
    end

    assign stage_d.a       = in_a;
    assign stage_d.b       = in_b;
    assign stage_d.eff_sub = ~eff_add;
    assign stage_d.neg     = ~in_a_pos; // the sign of a, stage three may flip it.

    ////////////////////
    // stage register.
    ////////////////////

    sm_pipe_reg #(
        .T(sm_resolve_t)
    ) u_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (stage_d),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

//--- hw/sm_magnitude_sub.sv
`timescale 1ns/1ns

`include "sm_alu_macros.svh"

// stage two of the sign-magnitude adder.
// one carry chain, a bit wider than the magnitude, gives either a+b or a-b.
// on a subtract the top bit of the chain doubles as the a < b compare.
module sm_magnitude_sub (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  sm_alu_pkg::sm_resolve_t in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output sm_alu_pkg::sm_diff_t    out_data,
    input  logic                    out_ready
);

    import sm_alu_pkg::*;

    sm_mag_t           b_op;  // b, inverted on a subtract.
    logic [`SM_WIDTH:0] chain; // extended sum, top bit is the carry out.
    sm_diff_t          stage_d;

    ////////////////////
    // carry chain.
    ////////////////////

    // a - b is formed as a + ~b + 1.
    assign b_op = in_data.b ^ {`SM_WIDTH{in_data.eff_sub}};

    assign chain = {1'b0, in_data.a}
                 + {1'b0, b_op}
                 + {{`SM_WIDTH{1'b0}}, in_data.eff_sub}; // the +1 of the negate.

    // on a subtract a missing carry out means a < b.
    // on an add the carry out is the wrap and gets dropped.
    assign stage_d.borrow  = in_data.eff_sub & ~chain[`SM_WIDTH];
    assign stage_d.diff    = chain[`SM_WIDTH-1:0]; // sum modulo 2^width.
    assign stage_d.eff_sub = in_data.eff_sub;
    assign stage_d.neg     = in_data.neg;

    ////////////////////
    // stage register.
    ////////////////////

    sm_pipe_reg #(
        .T(sm_diff_t)
    ) u_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (stage_d),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

//--- hw/sm_result_fix.sv
`timescale 1ns/1ns

// stage three of the sign-magnitude adder.
// a borrowed difference holds a-b in two's complement, so it is negated
// back to b-a and the sign taken from a is turned over.
module sm_result_fix (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  sm_alu_pkg::sm_diff_t   in_data,
    output logic                   in_ready,
    output logic                   out_valid,
    output sm_alu_pkg::sm_result_t out_data,
    input  logic                   out_ready
);

    import sm_alu_pkg::*;

    logic       negate;  // result has to be turned around.
    sm_result_t stage_d;

    ////////////////////
    // fix-up.
    ////////////////////

    // only a subtract can borrow.
    assign negate = in_data.eff_sub & in_data.borrow;

    always_comb begin
        if (negate) begin
            stage_d.mag = ~in_data.diff + 1'b1; // two's complement gives b - a.
            stage_d.neg = ~in_data.neg;         // b outweighs a.
        end else begin
            stage_d.mag = in_data.diff; // sum, or a - b with a >= b.
            stage_d.neg = in_data.neg;  // equal magnitudes keep a's sign.
        end
    end

    ////////////////////
    // stage register.
    ////////////////////

    sm_pipe_reg #(
        .T(sm_result_t)
    ) u_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (stage_d),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

//--- hw/sm_alu_top.sv
`timescale 1ns/1ns

// pipelined sign-magnitude adder/subtractor.
// three register stages in a row on one valid/ready stream.
// ready runs back from out_ready to in_ready without a register in the way.
module sm_alu_top (
    input  logic                clk,
    input  logic                arst_n,

    // input stream.
    input  logic                in_valid,
    output logic                in_ready,
    input  sm_alu_pkg::sm_op_e  in_op,    // requested add or subtract.
    input  sm_alu_pkg::sm_mag_t in_a,
    input  logic                in_a_pos, // 1 means positive or zero.
    input  sm_alu_pkg::sm_mag_t in_b,
    input  logic                in_b_pos, // 1 means positive or zero.

    // output stream.
    output logic                out_valid,
    input  logic                out_ready,
    output sm_alu_pkg::sm_mag_t out_mag,
    output logic                out_neg   // 1 means negative.
);

    import sm_alu_pkg::*;

    ////////////////////
    // stage links.
    ////////////////////

    logic        res_valid; // stage one to stage two.
    logic        res_ready;
    sm_resolve_t res_data;

    logic        diff_valid; // stage two to stage three.
    logic        diff_ready;
    sm_diff_t    diff_data;

    sm_result_t  fix_data; // stage three payload.

    ////////////////////
    // stages.
    ////////////////////

    sm_op_resolve u_resolve (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_a_pos  (in_a_pos),
        .in_b      (in_b),
        .in_b_pos  (in_b_pos),
        .in_ready  (in_ready),
        .out_valid (res_valid),
        .out_data  (res_data),
        .out_ready (res_ready)
    );

    sm_magnitude_sub u_sub (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (res_valid),
        .in_data   (res_data),
        .in_ready  (res_ready),
        .out_valid (diff_valid),
        .out_data  (diff_data),
        .out_ready (diff_ready)
    );

    sm_result_fix u_fix (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (diff_valid),
        .in_data   (diff_data),
        .in_ready  (diff_ready),
        .out_valid (out_valid),
        .out_data  (fix_data),
        .out_ready (out_ready)
    );

    // split the final payload onto the output ports.
    assign out_mag = fix_data.mag;
    assign out_neg = fix_data.neg;

endmodule

//--- tb/tb_sm_alu.sv
`timescale 1ns/1ns

`include "sm_alu_macros.svh"

// testbench for the pipelined sign-magnitude adder/subtractor.
// directed vectors come from a file, then a random run under back-pressure.
module tb_sm_alu;

    import sm_alu_pkg::*;

    localparam int CLK_PERIOD      = 8;  // ns.
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_DIRECTED    = 30; // vectors in the file.
    localparam int VEC_FIELDS      = 7;  // words per vector.
    localparam int RAND_COUNT      = 200;
    localparam int TOTAL_TESTS     = NUM_DIRECTED + RAND_COUNT;
    localparam int WATCHDOG_CYCLES = (TOTAL_TESTS + `SM_STAGES) * 20;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    logic    in_ready;
    sm_op_e  in_op;
    sm_mag_t in_a;
    logic    in_a_pos;
    sm_mag_t in_b;
    logic    in_b_pos;
    logic    out_valid;
    logic    out_ready;
    sm_mag_t out_mag;
    logic    out_neg;

    sm_mag_t drv_exp_mag; // expected result of the item now on the input.
    logic    drv_exp_neg;

    logic [31:0]        vec_mem [0:NUM_DIRECTED*VEC_FIELDS-1];
    logic [`SM_WIDTH:0] exp_q [$]; // {neg, mag}, oldest first.

    integer seed;
    integer pass_count;
    integer fail_count;  // bumped by the scoreboard only.
    integer misc_errors; // bumped by the main sequence only.
    integer recv_count;

    sm_alu_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_a_pos  (in_a_pos),
        .in_b      (in_b),
        .in_b_pos  (in_b_pos),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_mag   (out_mag),
        .out_neg   (out_neg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////
    // reference model.
    ////////////////////

    // effective operation and sign from the two sign bits, magnitudes compared unsigned.
    function automatic logic [`SM_WIDTH:0] model_result(
        input logic    op_sub,
        input logic    a_pos,
        input sm_mag_t a,
        input logic    b_pos,
        input sm_mag_t b
    );
        logic    eff_add;
        sm_mag_t mag;
        logic    neg;
        begin
            if (op_sub) begin
                eff_add = (a_pos != b_pos); // minus a negative is a plus.
            end else begin
                eff_add = (a_pos == b_pos);
            end
            if (eff_add) begin
                mag = a + b; // wraps modulo 2^width.
                neg = ~a_pos;
            end else if (a < b) begin
                mag = b - a;
                neg = a_pos; // b wins, so the sign turns over.
            end else begin
                mag = a - b;
                neg = ~a_pos; // a equal to b keeps a negative zero.
            end
            model_result = {neg, mag};
        end
    endfunction

    ////////////////////
    // driver.
    ////////////////////

    // called 1 ns after an edge; returns 1 ns after the edge that took the item.
    task automatic send_item(
        input logic    op_sub,
        input logic    a_pos,
        input sm_mag_t a,
        input logic    b_pos,
        input sm_mag_t b,
        input sm_mag_t exp_mag,
        input logic    exp_neg,
        input logic    toggle_ready
    );
        logic [31:0] rnd;
        begin
            in_op       = op_sub ? SM_SUB : SM_ADD;
            in_a_pos    = a_pos;
            in_a        = a;
            in_b_pos    = b_pos;
            in_b        = b;
            drv_exp_mag = exp_mag;
            drv_exp_neg = exp_neg;
            in_valid    = 1'b1;
            if (toggle_ready) begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end
            @(posedge clk);
            while (!in_ready) begin // data stays put while stalled.
                #1;
                if (toggle_ready) begin
                    rnd       = $random(seed);
                    out_ready = rnd[0];
                end
                @(posedge clk);
            end
            #1;
        end
    endtask

    // let the pipe empty with out_ready high, then check nothing is left.
    task automatic drain_pipe;
        integer waited;
        begin
            out_ready = 1'b1;
            waited    = 0;
            while (exp_q.size() != 0 && waited < 4 * `SM_STAGES) begin
                @(posedge clk);
                #1;
                waited = waited + 1;
            end
            if (exp_q.size() != 0) begin
                $display("t=%0t %0d results never came out of the pipe", $time, exp_q.size());
                misc_errors = misc_errors + 1;
            end
        end
    endtask

    ////////////////////
    // scoreboard.
    ////////////////////

    // samples at the edge, before the registers move.
    always @(posedge clk) begin
        logic [`SM_WIDTH:0] exp_item;
        logic               bad;
        if (arst_n) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("t=%0t a result came out with no input waiting for it", $time);
                    fail_count = fail_count + 1;
                end else begin
                    exp_item   = exp_q.pop_front();
                    recv_count = recv_count + 1;
                    bad        = 1'b0;
                    if (out_mag !== exp_item[`SM_WIDTH-1:0]) begin
                        $display("FAILED t=%0t out_mag expected %h got %h",
                                 $time, exp_item[`SM_WIDTH-1:0], out_mag);
                        bad = 1'b1;
                    end
                    if (out_neg !== exp_item[`SM_WIDTH]) begin
                        $display("FAILED t=%0t out_neg expected %b got %b",
                                 $time, exp_item[`SM_WIDTH], out_neg);
                        bad = 1'b1;
                    end
                    if (bad) begin
                        fail_count = fail_count + 1;
                    end else begin
                        pass_count = pass_count + 1;
                        $display("ok t=%0t result %0d mag %h neg %b",
                                 $time, recv_count, out_mag, out_neg);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back({drv_exp_neg, drv_exp_mag}); // accepted this edge.
            end
        end
    end

    ////////////////////
    // main sequence.
    ////////////////////

    initial begin
        integer  i;
        integer  base;
        integer  edges;
        logic    seen;
        logic    r_op;
        logic    r_apos;
        logic    r_bpos;
        sm_mag_t r_a;
        sm_mag_t r_b;
        logic [31:0]        rnd;
        logic [`SM_WIDTH:0] exp_item;

        seed        = 16;
        pass_count  = 0;
        fail_count  = 0;
        misc_errors = 0;
        recv_count  = 0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_op       = SM_ADD;
        in_a        = '0;
        in_a_pos    = 1'b1;
        in_b        = '0;
        in_b_pos    = 1'b1;
        out_ready   = 1'b0;
        drv_exp_mag = '0;
        drv_exp_neg = 1'b0;

        $readmemh("tb/sm_alu_tests.mem", vec_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;

        // an empty pipe shows nothing and takes input.
        if (out_valid !== 1'b0) begin
            $display("FAILED t=%0t out_valid expected 0 got %b", $time, out_valid);
            misc_errors = misc_errors + 1;
        end
        if (in_ready !== 1'b1) begin
            $display("FAILED t=%0t in_ready expected 1 got %b", $time, in_ready);
            misc_errors = misc_errors + 1;
        end

        if ($isunknown(vec_mem[NUM_DIRECTED*VEC_FIELDS-1])) begin
            $display("the test vector file is missing or shorter than expected");
            misc_errors = misc_errors + 1;
        end else begin
            // one lone item measures the latency.
            out_ready = 1'b1;
            send_item(vec_mem[0][0], vec_mem[1][0], vec_mem[2], vec_mem[3][0],
                      vec_mem[4], vec_mem[5], vec_mem[6][0], 1'b0);
            in_valid = 1'b0;
            edges    = 0;
            seen     = 1'b0;
            while (!seen && edges < 20) begin
                @(posedge clk);
                edges = edges + 1;
                seen  = out_valid;
            end
            #1;
            if (!seen) begin
                $display("t=%0t the first item never reached the output", $time);
                misc_errors = misc_errors + 1;
            end else if (edges != `SM_STAGES) begin
                $display("FAILED t=%0t out_valid latency expected %0d got %0d",
                         $time, `SM_STAGES, edges);
                misc_errors = misc_errors + 1;
            end

            // the rest of the directed vectors, back to back.
            for (i = 1; i < NUM_DIRECTED; i = i + 1) begin
                base = i * VEC_FIELDS;
                send_item(vec_mem[base][0], vec_mem[base+1][0], vec_mem[base+2],
                          vec_mem[base+3][0], vec_mem[base+4], vec_mem[base+5],
                          vec_mem[base+6][0], 1'b0);
            end
            in_valid = 1'b0;
            drain_pipe();

            // random items with out_ready redrawn at random every cycle.
            for (i = 0; i < RAND_COUNT; i = i + 1) begin
                rnd    = $random(seed);
                r_op   = rnd[0];
                r_apos = rnd[1];
                r_bpos = rnd[2];
                r_a    = $random(seed);
                r_b    = $random(seed);
                if (rnd[5:3] == 3'd0) begin
                    r_b = r_a; // equal magnitudes now and then.
                end
                exp_item = model_result(r_op, r_apos, r_a, r_bpos, r_b);
                send_item(r_op, r_apos, r_a, r_bpos, r_b,
                          exp_item[`SM_WIDTH-1:0], exp_item[`SM_WIDTH], 1'b1);
            end
            in_valid = 1'b0;
            drain_pipe();

            if (recv_count != TOTAL_TESTS) begin
                $display("sent %0d items but %0d results came back", TOTAL_TESTS, recv_count);
                misc_errors = misc_errors + 1;
            end
        end

        $display("tests done: %0d passed, %0d failed", pass_count, fail_count + misc_errors);
        if (fail_count == 0 && misc_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, sized from the number of tests.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the pipe stopped moving", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb/sm_alu_tests.mem
// columns: op a_pos a b_pos b exp_mag exp_neg, all hex, one vector per line.
// op 0 is add and 1 is subtract; a sign of 1 is positive or zero, exp_neg 1 is negative.
0 1 00000005 1 00000003 00000008 0
0 0 00000005 0 00000003 00000008 1
1 1 00000064 0 00000020 00000084 0
1 0 00000064 1 00000020 00000084 1
0 1 FFFFFFFF 1 00000002 00000001 0
0 0 80000000 0 80000000 00000000 1
1 1 12345678 0 11111111 23456789 0
0 1 DEADBEEF 1 10000000 EEADBEEF 0
1 1 00000010 1 00000003 0000000D 0
1 0 00000010 0 00000003 0000000D 1
0 1 00000010 0 00000003 0000000D 0
0 0 00000010 1 00000003 0000000D 1
1 1 00000003 1 00000010 0000000D 1
1 0 00000003 0 00000010 0000000D 0
0 1 00000003 0 00000010 0000000D 1
0 0 00000003 1 00000010 0000000D 0
1 1 00000000 1 FFFFFFFF FFFFFFFF 1
1 1 87654321 1 12345678 7530ECA9 0
0 1 12345678 0 87654321 7530ECA9 1
1 1 00000007 1 00000007 00000000 0
1 0 00000007 0 00000007 00000000 1
0 0 ABCDEF01 1 ABCDEF01 00000000 1
0 1 00000000 1 00000000 00000000 0
1 0 00000000 0 00000000 00000000 1
0 1 00000000 0 00000009 00000009 1
1 1 00000009 1 00000000 00000009 0
0 1 FFFFFFFF 1 FFFFFFFF FFFFFFFE 0
1 0 FFFFFFFF 0 FFFFFFFF 00000000 1
1 1 FFFFFFFF 0 00000001 00000000 0
0 0 00000001 1 FFFFFFFF FFFFFFFE 0

//--- build.f
+incdir+hw
hw/sm_alu_pkg.sv
hw/sm_pipe_reg.sv
hw/sm_op_resolve.sv
hw/sm_magnitude_sub.sv
hw/sm_result_fix.sv
hw/sm_alu_top.sv
tb/tb_sm_alu.sv

//--- Bender.yml
package:
  name: sm_alu

sources:
  - include_dirs:
      - hw
    files:
      - hw/sm_alu_pkg.sv
      - hw/sm_pipe_reg.sv
      - hw/sm_op_resolve.sv
      - hw/sm_magnitude_sub.sv
      - hw/sm_result_fix.sv
      - hw/sm_alu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_sm_alu.sv
